/* fetch_defs.svh */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// first fetch address out of reset
`define FETCH_RESET_PC      32'h0000_0000

`define FETCH_ADDR_W        32
`define FETCH_DATA_W        32
`define FETCH_COUNT_W       32

// rom depth in words
`define FETCH_IMEM_WORDS    16

// rv32 major opcodes seen by predecode
`define FETCH_OP_BRANCH     7'b1100011
`define FETCH_OP_JAL        7'b1101111
`define FETCH_OP_JALR       7'b1100111
`define FETCH_OP_SYSTEM     7'b1110011  // ecall, mret
`define FETCH_OP_MISCMEM    7'b0001111  // fence, fence.i

`endif

/* fetch_pkg.sv */
`include "fetch_defs.svh"

package fetch_pkg;

    typedef logic [`FETCH_ADDR_W-1:0]  addr_t;
    typedef logic [`FETCH_DATA_W-1:0]  instr_t;
    typedef logic [`FETCH_COUNT_W-1:0] count_t;

    // what predecode makes of a fetched word
    typedef enum logic [2:0] {
        OP_PLAIN,
        OP_BRANCH,
        OP_JAL,
        OP_INDIRECT,    // jalr, ecall, mret
        OP_FENCE        // fence.i
    } op_class_t;

    // pc sequencer
    typedef enum logic [1:0] {
        ST_WORK,        // streaming words to decode
        ST_BRANCH,      // predicted-path word held until resolution
        ST_WAIT,        // waiting for an indirect target
        ST_FENCE        // waiting for fence handshake
    } seq_state_t;

endpackage

/* imem_wb.sv */
`include "fetch_defs.svh"

module imem_wb
    import fetch_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   wb_cyc_i,
    input  logic   wb_stb_i,
    input  logic   wb_we_i,
    input  addr_t  wb_adr_i,
    output instr_t wb_dat_o,
    output logic   wb_ack_o
);

    localparam int IDX_W = $clog2(`FETCH_IMEM_WORDS);

    instr_t           rom [0:`FETCH_IMEM_WORDS-1];
    logic [IDX_W-1:0] idx;
    logic             access;
    logic             wait_q;   // first strobe cycle already seen

    initial begin
        $readmemh("program.hex", rom);
    end

    assign idx    = wb_adr_i[IDX_W+1:2];    // word index
    assign access = wb_cyc_i & wb_stb_i;

    // one wait state, ack on the second strobe cycle
    assign wb_ack_o = access & wait_q;

    // writes to the rom are ignored
    assign wb_dat_o = wb_we_i ? '0 : rom[idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_q <= 1'b0;
        end else if (!access || wb_ack_o) begin
            wait_q <= 1'b0;     // rearm for the next strobe
        end else begin
            wait_q <= 1'b1;
        end
    end

endmodule

/* fetch_wb_master.sv */
module fetch_wb_master
    import fetch_pkg::*;
(
    input  logic   clk,
    input  logic   rst,

    // from the sequencer
    input  logic   req_i,
    input  addr_t  req_addr_i,
    input  logic   flush_i,
    output logic   busy_o,

    // wishbone classic
    output logic   wb_cyc_o,
    output logic   wb_stb_o,
    output logic   wb_we_o,
    output addr_t  wb_adr_o,
    input  instr_t wb_dat_i,
    input  logic   wb_ack_i,

    // to predecode
    output logic   rsp_valid_o,
    output addr_t  rsp_pc_o,
    output instr_t rsp_instr_o
);

    logic  cyc_q;
    logic  stale_q;     // cycle in flight was flushed
    addr_t adr_q;
    logic  start;

    assign start = req_i & ~cyc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_q   <= 1'b0;
            stale_q <= 1'b0;
        end else if (start) begin
            cyc_q   <= 1'b1;
            stale_q <= 1'b0;
        end else if (cyc_q && wb_ack_i) begin
            cyc_q   <= 1'b0;    // cycle ends at ack
            stale_q <= 1'b0;
        end else if (cyc_q && flush_i) begin
            stale_q <= 1'b1;
        end
    end

    // address held for the whole cycle
    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= req_addr_i;
        end
    end

    assign busy_o   = cyc_q;
    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = cyc_q;
    assign wb_we_o  = 1'b0;     // read only
    assign wb_adr_o = adr_q;

    // a flush in the ack cycle also kills the word
    assign rsp_valid_o = cyc_q & wb_ack_i & ~stale_q & ~flush_i;
    assign rsp_pc_o    = adr_q;
    assign rsp_instr_o = wb_dat_i;

endmodule

/* predecode.sv */
`include "fetch_defs.svh"

module predecode
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rsp_valid_i,
    input  addr_t     rsp_pc_i,
    input  instr_t    rsp_instr_i,
    input  logic      flush_i,
    input  logic      take_i,
    output logic      valid_o,
    output addr_t     pc_o,
    output instr_t    instr_o,
    output op_class_t class_o,
    output addr_t     target_o,
    output logic      pred_taken_o
);

    logic        valid_q;
    addr_t       pc_q;
    instr_t      instr_q;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [11:0] funct12;
    addr_t       imm_b;
    addr_t       imm_j;
    addr_t       br_target;
    addr_t       jal_target;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;    // wrong-path word dropped
        end else if (rsp_valid_i) begin
            valid_q <= 1'b1;
        end else if (take_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid_i) begin
            pc_q    <= rsp_pc_i;
            instr_q <= rsp_instr_i;
        end
    end

    assign opcode  = instr_q[6:0];
    assign funct3  = instr_q[14:12];
    assign funct12 = instr_q[31:20];

    // b and j immediates, sign extended
    assign imm_b = {{20{instr_q[31]}}, instr_q[7], instr_q[30:25], instr_q[11:8], 1'b0};
    assign imm_j = {{12{instr_q[31]}}, instr_q[19:12], instr_q[20], instr_q[30:21], 1'b0};

    assign br_target  = pc_q + imm_b;
    assign jal_target = pc_q + imm_j;

    always_comb begin
        class_o = OP_PLAIN;
        case (opcode)
            `FETCH_OP_BRANCH: class_o = OP_BRANCH;
            `FETCH_OP_JAL:    class_o = OP_JAL;
            `FETCH_OP_JALR:   class_o = OP_INDIRECT;
            `FETCH_OP_SYSTEM: begin
                // ecall 0x000, mret 0x302
                if (funct3 == 3'b000 && (funct12 == 12'h000 || funct12 == 12'h302)) begin
                    class_o = OP_INDIRECT;
                end
            end
            `FETCH_OP_MISCMEM: begin
                if (funct3 == 3'b001) begin
                    class_o = OP_FENCE;
                end
            end
            default: ;
        endcase
    end

    assign valid_o  = valid_q;
    assign pc_o     = pc_q;
    assign instr_o  = instr_q;
    assign target_o = (class_o == OP_JAL) ? jal_target : br_target;

    // backward taken, forward not taken
    assign pred_taken_o = (class_o == OP_BRANCH) && (br_target < pc_q);

endmodule

/* fetch_seq.sv */
`include "fetch_defs.svh"

module fetch_seq
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // predecode
    input  logic      pd_valid_i,
    input  addr_t     pd_pc_i,
    input  instr_t    pd_instr_i,
    input  op_class_t pd_class_i,
    input  addr_t     pd_target_i,
    input  logic      pd_pred_i,

    // bus master
    input  logic      busy_i,
    output logic      req_o,
    output addr_t     req_addr_o,
    output logic      flush_o,
    output logic      take_o,

    // decode
    output logic      out_valid_o,
    output addr_t     out_pc_o,
    output instr_t    out_instr_o,
    input  logic      out_ready_i,

    // back end
    input  logic      resolve_valid_i,
    input  logic      resolve_taken_i,
    input  addr_t     resolve_target_i,
    output logic      fence_req_o,
    input  logic      fence_done_i,
    output count_t    hit_count_o,
    output count_t    miss_count_o
);

    seq_state_t state_q;
    seq_state_t state_d;
    addr_t      seq_pc;         // fall-through of the word in predecode
    addr_t      alt_q;          // other branch path, or resume after fence.i
    logic       pred_q;
    logic       live_q;
    logic       pend_q;         // request owed but master was busy
    addr_t      pend_addr_q;
    logic       issue_want;
    addr_t      issue_addr;
    logic       hit;
    logic       room;

    assign seq_pc = pd_pc_i + 32'd4;

    // words only leave in work, so the speculative one stays held in branch
    assign out_valid_o = (state_q == ST_WORK) & pd_valid_i;
    assign out_pc_o    = pd_pc_i;
    assign out_instr_o = pd_instr_i;
    assign take_o      = out_valid_o & out_ready_i;

    assign hit         = (resolve_taken_i == pred_q);
    assign fence_req_o = (state_q == ST_FENCE);

    always_comb begin
        state_d    = state_q;
        issue_want = 1'b0;
        issue_addr = seq_pc;
        flush_o    = 1'b0;
        case (state_q)
            ST_WORK: begin
                if (take_o) begin
                    case (pd_class_i)
                        OP_PLAIN: issue_want = 1'b1;
                        OP_JAL: begin
                            issue_want = 1'b1;
                            issue_addr = pd_target_i;
                            flush_o    = 1'b1;
                        end
                        OP_BRANCH: begin
                            issue_want = 1'b1;  // predicted path
                            if (pd_pred_i) begin
                                issue_addr = pd_target_i;
                            end
                            state_d = ST_BRANCH;
                        end
                        OP_INDIRECT: state_d = ST_WAIT;
                        OP_FENCE:    state_d = ST_FENCE;
                        default: ;
                    endcase
                end
            end
            ST_BRANCH: begin
                if (resolve_valid_i) begin
                    state_d = ST_WORK;          // hit releases the held word
                    if (!hit) begin
                        flush_o    = 1'b1;
                        issue_want = 1'b1;
                        issue_addr = alt_q;
                    end
                end
            end
            ST_WAIT: begin
                if (resolve_valid_i) begin
                    state_d    = ST_WORK;
                    issue_want = 1'b1;
                    issue_addr = resolve_target_i;
                end
            end
            ST_FENCE: begin
                if (fence_done_i) begin
                    state_d    = ST_WORK;
                    issue_want = 1'b1;
                    issue_addr = alt_q;
                end
            end
            default: state_d = ST_WORK;
        endcase
    end

    // predecode must be free by the time the new word lands
    assign room       = ~pd_valid_i | take_o | flush_o;
    assign req_o      = (pend_q | issue_want) & ~busy_i & room;
    assign req_addr_o = pend_q ? pend_addr_q : issue_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= ST_WORK;
            live_q       <= 1'b0;
            pend_q       <= 1'b0;
            pend_addr_q  <= `FETCH_RESET_PC;
            hit_count_o  <= '0;
            miss_count_o <= '0;
        end else begin
            state_q <= state_d;
            live_q  <= 1'b1;
            if (!live_q) begin
                pend_q <= 1'b1;             // first fetch after reset
            end else if (issue_want && !req_o) begin
                pend_q      <= 1'b1;        // stale cycle still on the bus
                pend_addr_q <= issue_addr;
            end else if (req_o) begin
                pend_q <= 1'b0;
            end
            if (state_q == ST_BRANCH && resolve_valid_i) begin
                if (hit) begin
                    hit_count_o <= hit_count_o + 1'b1;
                end else begin
                    miss_count_o <= miss_count_o + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_o) begin
            pred_q <= pd_pred_i;
            alt_q  <= (pd_class_i == OP_FENCE || pd_pred_i) ? seq_pc : pd_target_i;
        end
    end

endmodule

/* fetch_top.sv */
module fetch_top
    import fetch_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    output logic   out_valid_o,
    output addr_t  out_pc_o,
    output instr_t out_instr_o,
    input  logic   out_ready_i,
    input  logic   resolve_valid_i,
    input  logic   resolve_taken_i,
    input  addr_t  resolve_target_i,
    output logic   fence_req_o,
    input  logic   fence_done_i,
    output count_t hit_count_o,
    output count_t miss_count_o
);

    // sequencer <-> master
    logic      req;
    addr_t     req_addr;
    logic      busy;
    logic      flush;

    // wishbone
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    addr_t     wb_adr;
    instr_t    wb_dat;
    logic      wb_ack;

    // master -> predecode
    logic      rsp_valid;
    addr_t     rsp_pc;
    instr_t    rsp_instr;

    // predecode -> sequencer
    logic      pd_valid;
    addr_t     pd_pc;
    instr_t    pd_instr;
    op_class_t pd_class;
    addr_t     pd_target;
    logic      pd_pred;
    logic      take;

    fetch_seq u_seq (
        .clk              (clk),
        .rst              (rst),
        .pd_valid_i       (pd_valid),
        .pd_pc_i          (pd_pc),
        .pd_instr_i       (pd_instr),
        .pd_class_i       (pd_class),
        .pd_target_i      (pd_target),
        .pd_pred_i        (pd_pred),
        .busy_i           (busy),
        .req_o            (req),
        .req_addr_o       (req_addr),
        .flush_o          (flush),
        .take_o           (take),
        .out_valid_o      (out_valid_o),
        .out_pc_o         (out_pc_o),
        .out_instr_o      (out_instr_o),
        .out_ready_i      (out_ready_i),
        .resolve_valid_i  (resolve_valid_i),
        .resolve_taken_i  (resolve_taken_i),
        .resolve_target_i (resolve_target_i),
        .fence_req_o      (fence_req_o),
        .fence_done_i     (fence_done_i),
        .hit_count_o      (hit_count_o),
        .miss_count_o     (miss_count_o)
    );

    fetch_wb_master u_master (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req),
        .req_addr_i  (req_addr),
        .flush_i     (flush),
        .busy_o      (busy),
        .wb_cyc_o    (wb_cyc),
        .wb_stb_o    (wb_stb),
        .wb_we_o     (wb_we),
        .wb_adr_o    (wb_adr),
        .wb_dat_i    (wb_dat),
        .wb_ack_i    (wb_ack),
        .rsp_valid_o (rsp_valid),
        .rsp_pc_o    (rsp_pc),
        .rsp_instr_o (rsp_instr)
    );

    predecode u_pd (
        .clk          (clk),
        .rst          (rst),
        .rsp_valid_i  (rsp_valid),
        .rsp_pc_i     (rsp_pc),
        .rsp_instr_i  (rsp_instr),
        .flush_i      (flush),
        .take_i       (take),
        .valid_o      (pd_valid),
        .pc_o         (pd_pc),
        .instr_o      (pd_instr),
        .class_o      (pd_class),
        .target_o     (pd_target),
        .pred_taken_o (pd_pred)
    );

    imem_wb u_imem (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_o (wb_dat),
        .wb_ack_o (wb_ack)
    );

endmodule

/* fetch_asserts.sv */
module fetch_asserts
    import fetch_pkg::*;
(
    input logic   clk,
    input logic   rst,
    input logic   wb_cyc_i,
    input logic   wb_stb_i,
    input addr_t  wb_adr_i,
    input logic   wb_ack_i,
    input logic   out_valid_i,
    input logic   out_ready_i,
    input addr_t  out_pc_i,
    input instr_t out_instr_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int assert_fails = 0;   // read by the testbench at the end

    stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb_i |-> wb_cyc_i)
        else begin
            $error("wishbone stb raised outside a bus cycle");
            assert_fails++;
        end

    // classic cycle, master holds the address until ack
    adr_until_ack: assert property (@(posedge clk) disable iff (rst)
        wb_stb_i && !wb_ack_i |=> wb_stb_i && $stable(wb_adr_i))
        else begin
            $error("wishbone address or strobe changed before ack");
            assert_fails++;
        end

    valid_until_ready: assert property (@(posedge clk) disable iff (rst)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_pc_i)
            && $stable(out_instr_i))
        else begin
            $error("decode word dropped or changed before ready");
            assert_fails++;
        end

endmodule

/* fetch_tb.sv */
`include "fetch_defs.svh"

module fetch_tb
    import fetch_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_ACCEPT       = 200;
    localparam int TIMEOUT_CYCLES = N_ACCEPT * 20;
    localparam int IDX_W          = $clog2(`FETCH_IMEM_WORDS);

    // instruction kinds as the back end sees them
    localparam int K_PLAIN    = 0;
    localparam int K_BRANCH   = 1;
    localparam int K_JAL      = 2;
    localparam int K_INDIRECT = 3;
    localparam int K_FENCE    = 4;

    logic   clk;
    logic   rst;
    logic   out_valid;
    addr_t  out_pc;
    instr_t out_instr;
    logic   out_ready;
    logic   resolve_valid;
    logic   resolve_taken;
    addr_t  resolve_target;
    logic   fence_req;
    logic   fence_done;
    count_t hit_count;
    count_t miss_count;

    instr_t      mem [0:`FETCH_IMEM_WORDS-1];
    logic [31:0] lfsr_q;
    int          errors;
    int          checks;
    int          n_accepted;
    int          reset_edges;
    logic        stop_ready;
    logic        ev_active;     // resolve or fence done still owed
    int          ev_delay;
    int          ev_kind;
    logic        last_taken;
    addr_t       last_target;
    count_t      exp_hits;
    count_t      exp_misses;
    logic        have_prev;
    addr_t       prev_pc;
    instr_t      prev_word;
    logic        in_fence;
    logic        fence_ended;
    logic        hold_q;
    addr_t       hold_pc;
    instr_t      hold_word;

    fetch_top dut0 (
        .clk              (clk),
        .rst              (rst),
        .out_valid_o      (out_valid),
        .out_pc_o         (out_pc),
        .out_instr_o      (out_instr),
        .out_ready_i      (out_ready),
        .resolve_valid_i  (resolve_valid),
        .resolve_taken_i  (resolve_taken),
        .resolve_target_i (resolve_target),
        .fence_req_o      (fence_req),
        .fence_done_i     (fence_done),
        .hit_count_o      (hit_count),
        .miss_count_o     (miss_count)
    );

    bind fetch_top fetch_asserts u_asserts (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc_i    (wb_cyc),
        .wb_stb_i    (wb_stb),
        .wb_adr_i    (wb_adr),
        .wb_ack_i    (wb_ack),
        .out_valid_i (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_pc_i    (out_pc_o),
        .out_instr_i (out_instr_o)
    );

    function automatic int word_kind(instr_t w);
        case (w[6:0])
            `FETCH_OP_BRANCH:  return K_BRANCH;
            `FETCH_OP_JAL:     return K_JAL;
            `FETCH_OP_JALR:    return K_INDIRECT;
            `FETCH_OP_SYSTEM:  begin
                if (w[14:12] == 3'd0 && (w[31:20] == 12'h000 || w[31:20] == 12'h302)) begin
                    return K_INDIRECT;  // ecall, mret
                end
                return K_PLAIN;
            end
            `FETCH_OP_MISCMEM: return (w[14:12] == 3'd1) ? K_FENCE : K_PLAIN;
            default:           return K_PLAIN;
        endcase
    endfunction

    function automatic addr_t b_offset(instr_t w);
        logic [12:0] imm;
        imm = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        return {{19{imm[12]}}, imm};
    endfunction

    function automatic addr_t j_offset(instr_t w);
        logic [20:0] imm;
        imm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        return {{11{imm[20]}}, imm};
    endfunction

    // static rule, backward branches taken
    function automatic logic backward_taken(addr_t pc, instr_t w);
        return (pc + b_offset(w)) < pc;
    endfunction

    // architectural successor of one instruction
    function automatic addr_t next_pc(addr_t pc, instr_t w, logic taken, addr_t target);
        case (word_kind(w))
            K_BRANCH:   return taken ? pc + b_offset(w) : pc + 32'd4;
            K_JAL:      return pc + j_offset(w);
            K_INDIRECT: return target;
            default:    return pc + 32'd4;
        endcase
    endfunction

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = (val << 1) | int'(lfsr_q[0]);
        end
    endtask

    task automatic fire_event(input int kind);
        if (kind == K_FENCE) begin
            fence_done <= 1'b1;
        end else begin
            resolve_valid <= 1'b1;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("[ERROR] %0t %s", $time, what);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // back end: decode ready, branch outcomes, resolve and fence latency
    always @(posedge clk) begin : back_end
        int    r;
        int    kind;
        addr_t target;
        resolve_valid <= 1'b0;
        fence_done    <= 1'b0;
        if (!rst) begin
            draw_bits(1, r);
            out_ready <= (r == 1) && !stop_ready;
            if (ev_active) begin
                if (ev_delay == 0) begin
                    fire_event(ev_kind);
                    ev_active <= 1'b0;
                end else begin
                    ev_delay <= ev_delay - 1;
                end
            end
            if (out_valid && out_ready) begin
                kind = word_kind(out_instr);
                if (kind == K_BRANCH) begin
                    draw_bits(1, r);
                    resolve_taken <= (r == 1);
                    last_taken    <= (r == 1);
                    if ((r == 1) == backward_taken(out_pc, out_instr)) begin
                        exp_hits <= exp_hits + 32'd1;
                    end else begin
                        exp_misses <= exp_misses + 32'd1;
                    end
                end
                if (kind == K_INDIRECT) begin
                    // jalr back to start+8, mret to start
                    target = (out_instr[6:0] == `FETCH_OP_JALR) ?
                             `FETCH_RESET_PC + 32'd8 : `FETCH_RESET_PC;
                    resolve_target <= target;
                    last_target    <= target;
                end
                if (kind == K_BRANCH || kind == K_INDIRECT || kind == K_FENCE) begin
                    draw_bits(2, r);
                    if (r == 0) begin
                        fire_event(kind);
                    end else begin
                        ev_active <= 1'b1;
                        ev_delay  <= r - 1;
                        ev_kind   <= kind;
                    end
                end
            end
        end
    end

    // compare accepted words against the reference sequence
    always @(posedge clk) begin : compare
        addr_t  exp_pc;
        instr_t exp_word;
        if (rst) begin
            if (reset_edges > 0) begin
                if (out_valid !== 1'b0) report_failure("out_valid_o high during reset");
                if (fence_req !== 1'b0) report_failure("fence_req_o high during reset");
            end
            reset_edges++;
        end else begin
            if (in_fence) begin
                if (fence_req !== 1'b1) report_mismatch("fence_req_o", 32'd1, 32'(fence_req));
                if (out_valid && out_ready) begin
                    report_failure("instruction accepted while fence.i was pending");
                end
                if (fence_done) begin
                    in_fence    = 1'b0;
                    fence_ended = 1'b1;
                end
            end else if (fence_ended) begin
                if (fence_req !== 1'b0) report_mismatch("fence_req_o", 32'd0, 32'(fence_req));
                fence_ended = 1'b0;
            end
            if (out_valid && out_ready) begin
                exp_pc = have_prev ? next_pc(prev_pc, prev_word, last_taken, last_target)
                                   : `FETCH_RESET_PC;
                exp_word = mem[exp_pc[IDX_W+1:2]];
                checks++;
                if (out_pc !== exp_pc) report_mismatch("out_pc_o", exp_pc, out_pc);
                if (out_instr !== exp_word) begin
                    report_mismatch("out_instr_o", exp_word, out_instr);
                end
                if (hit_count !== exp_hits) report_mismatch("hit_count_o", exp_hits, hit_count);
                if (miss_count !== exp_misses) begin
                    report_mismatch("miss_count_o", exp_misses, miss_count);
                end
                if (word_kind(exp_word) == K_FENCE) in_fence = 1'b1;
                prev_pc   = exp_pc;
                prev_word = exp_word;
                have_prev = 1'b1;
                n_accepted++;
                if (n_accepted == N_ACCEPT) stop_ready <= 1'b1;
            end
        end
    end

    // word must stay put while decode stalls
    always @(posedge clk) begin : stall_check
        if (!rst && hold_q) begin
            if (out_valid !== 1'b1) report_failure("out_valid_o dropped before ready");
            if (out_pc !== hold_pc) report_mismatch("out_pc_o", hold_pc, out_pc);
            if (out_instr !== hold_word) report_mismatch("out_instr_o", hold_word, out_instr);
        end
        hold_q    = !rst && out_valid && !out_ready;
        hold_pc   = out_pc;
        hold_word = out_instr;
    end

    initial begin
        rst            = 1'b1;
        out_ready      = 1'b0;
        resolve_valid  = 1'b0;
        resolve_taken  = 1'b0;
        resolve_target = '0;
        fence_done     = 1'b0;
        lfsr_q         = 32'hd84b_2fc6;
        errors         = 0;
        checks         = 0;
        n_accepted     = 0;
        reset_edges    = 0;
        stop_ready     = 1'b0;
        ev_active      = 1'b0;
        ev_delay       = 0;
        ev_kind        = K_PLAIN;
        last_taken     = 1'b0;
        last_target    = '0;
        exp_hits       = '0;
        exp_misses     = '0;
        have_prev      = 1'b0;
        in_fence       = 1'b0;
        fence_ended    = 1'b0;
        hold_q         = 1'b0;
        $readmemh("program.hex", mem);
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        wait (stop_ready);
        // let the last branch or fence settle
        repeat (2) @(posedge clk);
        while (ev_active || resolve_valid || fence_done) @(posedge clk);
        repeat (3) @(posedge clk);
        if (hit_count !== exp_hits) report_mismatch("hit_count_o", exp_hits, hit_count);
        if (miss_count !== exp_misses) report_mismatch("miss_count_o", exp_misses, miss_count);
        $display("accepted %0d, checks %0d, errors %0d, assertion failures %0d",
                 n_accepted, checks, errors, dut0.u_asserts.assert_fails);
        if (errors == 0 && dut0.u_asserts.assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("[ERROR] %0t run did not finish within %0d cycles, %0d words accepted",
                 $time, TIMEOUT_CYCLES, n_accepted);
        $display("accepted %0d, checks %0d, errors %0d", n_accepted, checks, errors + 1);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* program.hex */
// one 32-bit instruction word per line, word 0 at address 0
00000093
00110113
fe314ee3
00315863
00500213
0100006f
00700293
0000100f
00008067
00100313
30200073
00000013
00000013
00000013

/* fetch.f */
+incdir+.
fetch_pkg.sv
imem_wb.sv
fetch_wb_master.sv
predecode.sv
fetch_seq.sv
fetch_top.sv
fetch_asserts.sv
fetch_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps -Wno-fatal
TOP       = fetch_tb
FILELIST  = fetch.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
